// ==== cgra_array.f ====
verilog/cgra_pkg.sv
verilog/cgra_fu_pkg.sv
verilog/cgra_bus_if.sv
verilog/cgra_conf_regs.sv
verilog/cgra_data_mem.sv
verilog/cgra_alu.sv
verilog/cgra_core.sv
verilog/cgra_top.sv
sim/cgra_tb.sv

// ==== Bender.yml ====
package:
  name: cgra_array

sources:
  - verilog/cgra_pkg.sv
  - verilog/cgra_fu_pkg.sv
  - verilog/cgra_bus_if.sv
  - verilog/cgra_conf_regs.sv
  - verilog/cgra_data_mem.sv
  - verilog/cgra_alu.sv
  - verilog/cgra_core.sv
  - verilog/cgra_top.sv
  - target: simulation
    files:
      - sim/cgra_tb.sv

// ==== sim/cgra_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_tb;

   localparam int N_RUNS = 11;
   // Setup traffic, then per run the operand refresh, polling and result readback
   localparam int WATCHDOG_CYCLES =
      1000 + N_RUNS * (40 + 3 * cgra_pkg::N_CORE * cgra_pkg::BANK_WORDS);

   logic                 clk;
   logic                 rst;
   logic                 ctr_req;
   logic                 ctr_rnw;
   cgra_pkg::host_addr_t ctr_addr;
   cgra_pkg::data_t      ctr_data_to_wr;
   cgra_pkg::data_t      ctr_data_to_rd;
   logic                 databus_req;
   logic                 databus_rnw;
   cgra_pkg::host_addr_t databus_addr;
   cgra_pkg::data_t      databus_data_in;
   cgra_pkg::data_t      databus_data_out;

   // Shadow model of banks, registers and run timing
   cgra_pkg::data_t sh_a [cgra_pkg::N_CORE][cgra_pkg::BANK_WORDS];
   cgra_pkg::data_t sh_b [cgra_pkg::N_CORE][cgra_pkg::BANK_WORDS];
   cgra_pkg::data_t sh_r [cgra_pkg::N_CORE][cgra_pkg::BANK_WORDS];
   logic [2:0]      sh_op [cgra_pkg::N_CORE];
   int              sh_len [cgra_pkg::N_CORE];
   logic            sh_src [cgra_pkg::N_CORE];
   bit              ran [cgra_pkg::N_CORE];
   int              run_edge [cgra_pkg::N_CORE];
   int              run_len [cgra_pkg::N_CORE];

   cgra_pkg::data_t ctr_exp_q [$];
   string           ctr_tag_q [$];
   cgra_pkg::data_t data_exp_q [$];
   string           data_tag_q [$];
   logic            ctr_pend;
   logic            data_pend;
   logic [31:0]     lcg_state;
   int              edge_cnt;
   int              err_cnt;
   int              n_checks;

   cgra_top cgra_top_i (
      .clk              (clk),
      .rst              (rst),
      .ctr_req          (ctr_req),
      .ctr_rnw          (ctr_rnw),
      .ctr_addr         (ctr_addr),
      .ctr_data_to_wr   (ctr_data_to_wr),
      .ctr_data_to_rd   (ctr_data_to_rd),
      .databus_req      (databus_req),
      .databus_rnw      (databus_rnw),
      .databus_addr     (databus_addr),
      .databus_data_in  (databus_data_in),
      .databus_data_out (databus_data_out)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;
      end
   end

   function automatic cgra_pkg::data_t rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state[31:16];
   endfunction

   function automatic cgra_pkg::data_t alu_ref(input logic [2:0] op, input cgra_pkg::data_t a,
                                               input cgra_pkg::data_t b);
      logic [31:0] prod;
      prod = a * b;
      case (op)
         cgra_fu_pkg::OP_ADD:  return a + b;
         cgra_fu_pkg::OP_SUB:  return a - b;
         cgra_fu_pkg::OP_AND:  return a & b;
         cgra_fu_pkg::OP_OR:   return a | b;
         cgra_fu_pkg::OP_XOR:  return a ^ b;
         cgra_fu_pkg::OP_MUL:  return prod[15:0];
         cgra_fu_pkg::OP_MAX:  return (a > b) ? a : b;
         default:              return a;
      endcase
   endfunction

   function automatic int clamp_len(input cgra_pkg::data_t v);
      if (v == 0) return 1;
      if (v > cgra_pkg::BANK_WORDS) return cgra_pkg::BANK_WORDS;
      return int'(v);
   endfunction

   // Busy from the edge after the run write through run length plus two
   function automatic bit is_busy(input int k, input int n);
      return ran[k] && (n - run_edge[k] <= run_len[k] + 2);
   endfunction

   function automatic bit any_busy(input int n);
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         if (is_busy(k, n)) return 1'b1;
      end
      return 1'b0;
   endfunction

   function automatic cgra_pkg::data_t reg_ref(input int k, input cgra_pkg::local_addr_t addr,
                                               input int n);
      case (addr)
         cgra_pkg::REG_STATUS: begin
            if (!ran[k]) return '0;
            return is_busy(k, n) ? 16'h0001 : 16'h0002;
         end
         cgra_pkg::REG_OPCODE: return cgra_pkg::data_t'(sh_op[k]);
         cgra_pkg::REG_LENGTH: return cgra_pkg::data_t'(sh_len[k]);
         cgra_pkg::REG_SRC_B:  return cgra_pkg::data_t'(sh_src[k]);
         default:              return '0;
      endcase
   endfunction

   function automatic cgra_pkg::host_addr_t host_addr(input int k,
                                                      input cgra_pkg::local_addr_t loc);
      return {cgra_pkg::core_sel_t'(k), loc};
   endfunction

   function automatic cgra_pkg::local_addr_t mem_addr(input logic [1:0] bank, input int idx);
      return {2'b00, bank, cgra_pkg::word_idx_t'(idx)};
   endfunction

   // Models run acceptance at edge n and computes the expected result banks
   task automatic start_run(input int n);
      bit              acc [cgra_pkg::N_CORE];
      int              p;
      cgra_pkg::data_t b;
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         acc[k] = !is_busy(k, n);
         if (acc[k]) begin
            ran[k]      = 1'b1;
            run_edge[k] = n;
            run_len[k]  = sh_len[k];
         end
      end
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         p = (k + cgra_pkg::N_CORE - 1) % cgra_pkg::N_CORE;
         for (int i = 0; i < run_len[k] && acc[k]; i++) begin
            if (sh_src[k]) b = (i < run_len[p]) ? sh_a[p][i] : '0;
            else b = sh_b[k][i];
            sh_r[k][i] = alu_ref(sh_op[k], sh_a[k][i], b);
         end
      end
   endtask

   task automatic tick();
      @(posedge clk);
      edge_cnt++;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         tick();
         ctr_req     <= 1'b0;
         databus_req <= 1'b0;
      end
   endtask

   task automatic ctrl_write(input int k, input cgra_pkg::local_addr_t addr,
                             input cgra_pkg::data_t wdata);
      tick();
      ctr_req        <= 1'b1;
      ctr_rnw        <= 1'b0;
      ctr_addr       <= host_addr(k, addr);
      ctr_data_to_wr <= wdata;
      databus_req    <= 1'b0;
      case (addr)
         cgra_pkg::REG_RUN:    start_run(edge_cnt + 1);
         cgra_pkg::REG_OPCODE: sh_op[k] = wdata[2:0];
         cgra_pkg::REG_LENGTH: sh_len[k] = clamp_len(wdata);
         cgra_pkg::REG_SRC_B:  sh_src[k] = wdata[0];
         default: ;
      endcase
   endtask

   task automatic ctrl_read(input int k, input cgra_pkg::local_addr_t addr);
      tick();
      ctr_req     <= 1'b1;
      ctr_rnw     <= 1'b1;
      ctr_addr    <= host_addr(k, addr);
      databus_req <= 1'b0;
      ctr_exp_q.push_back(reg_ref(k, addr, edge_cnt + 1));
      ctr_tag_q.push_back($sformatf("core %0d register %0d", k, addr));
   endtask

   task automatic data_write(input int k, input logic [1:0] bank, input int idx,
                             input cgra_pkg::data_t wdata);
      tick();
      databus_req     <= 1'b1;
      databus_rnw     <= 1'b0;
      databus_addr    <= host_addr(k, mem_addr(bank, idx));
      databus_data_in <= wdata;
      ctr_req         <= 1'b0;
      // Host writes to bank R are dropped
      if (bank == cgra_pkg::BANK_A) sh_a[k][idx] = wdata;
      if (bank == cgra_pkg::BANK_B) sh_b[k][idx] = wdata;
   endtask

   task automatic data_read(input int k, input logic [1:0] bank, input int idx);
      tick();
      databus_req  <= 1'b1;
      databus_rnw  <= 1'b1;
      databus_addr <= host_addr(k, mem_addr(bank, idx));
      ctr_req      <= 1'b0;
      if (bank == cgra_pkg::BANK_A) data_exp_q.push_back(sh_a[k][idx]);
      else if (bank == cgra_pkg::BANK_B) data_exp_q.push_back(sh_b[k][idx]);
      else data_exp_q.push_back(sh_r[k][idx]);
      data_tag_q.push_back($sformatf("core %0d bank %0d word %0d", k, bank, idx));
   endtask

   task automatic fill_operands();
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         for (int i = 0; i < cgra_pkg::BANK_WORDS; i++) begin
            data_write(k, cgra_pkg::BANK_A, i, rand_word());
            data_write(k, cgra_pkg::BANK_B, i, rand_word());
         end
      end
   endtask

   task automatic read_bank(input logic [1:0] bank);
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         for (int i = 0; i < cgra_pkg::BANK_WORDS; i++) begin
            data_read(k, bank, i);
         end
      end
   endtask

   task automatic config_core(input int k, input int op, input int len, input int src);
      ctrl_write(k, cgra_pkg::REG_OPCODE, cgra_pkg::data_t'(op));
      ctrl_write(k, cgra_pkg::REG_LENGTH, cgra_pkg::data_t'(len));
      ctrl_write(k, cgra_pkg::REG_SRC_B, cgra_pkg::data_t'(src));
   endtask

   // Start all cores, watch one core's status every cycle, then read every result bank
   task automatic run_and_check(input int watch, input bit disturb);
      ctrl_write(watch, cgra_pkg::REG_RUN, 16'h0000);
      if (disturb) begin
         // Second run while busy, then A[0] rewritten after the engine fetched it
         ctrl_write(watch ^ 1, cgra_pkg::REG_RUN, 16'h0000);
         for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
            data_write(k, cgra_pkg::BANK_A, 0, rand_word());
         end
      end
      while (edge_cnt + 1 <= run_edge[watch] + run_len[watch] + 4) begin
         ctrl_read(watch, cgra_pkg::REG_STATUS);
      end
      while (any_busy(edge_cnt + 1)) begin
         idle(1);
      end
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         ctrl_read(k, cgra_pkg::REG_STATUS);
      end
      read_bank(cgra_pkg::BANK_R);
   endtask

   task automatic compare_word(input string what, input cgra_pkg::data_t got,
                               input cgra_pkg::data_t exp);
      n_checks++;
      assert (got === exp) else begin
         err_cnt++;
         $display("ERROR %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
      end
   endtask

   // Read data is stable from the edge after the request until the next edge
   always @(negedge clk) begin
      if (ctr_pend) begin
         compare_word(ctr_tag_q.pop_front(), ctr_data_to_rd, ctr_exp_q.pop_front());
      end
      if (data_pend) begin
         compare_word(data_tag_q.pop_front(), databus_data_out, data_exp_q.pop_front());
      end
      ctr_pend  = ctr_req && ctr_rnw;
      data_pend = databus_req && databus_rnw;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: the test did not complete within %0d clock cycles", WATCHDOG_CYCLES);
      $display("STATUS: FAIL");
      $finish;
   end

   initial begin
      rst             = 1'b1;
      ctr_req         = 1'b0;
      ctr_rnw         = 1'b0;
      ctr_addr        = '0;
      ctr_data_to_wr  = '0;
      databus_req     = 1'b0;
      databus_rnw     = 1'b0;
      databus_addr    = '0;
      databus_data_in = '0;
      ctr_pend        = 1'b0;
      data_pend       = 1'b0;
      lcg_state       = 32'h91307ee8;
      edge_cnt        = 0;
      err_cnt         = 0;
      n_checks        = 0;
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         sh_op[k]    = cgra_fu_pkg::OP_ADD;
         sh_len[k]   = 1;
         sh_src[k]   = 1'b0;
         ran[k]      = 1'b0;
         run_edge[k] = 0;
         run_len[k]  = 0;
         for (int i = 0; i < cgra_pkg::BANK_WORDS; i++) begin
            sh_a[k][i] = 'x;
            sh_b[k][i] = 'x;
            sh_r[k][i] = 'x;
         end
      end
      repeat (4) tick();
      rst <= 1'b0;

      // Both read ports return zero before any read
      @(negedge clk);
      compare_word("control bus after reset", ctr_data_to_rd, '0);
      compare_word("data bus after reset", databus_data_out, '0);

      // Reset values, then register writes with length clamping
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         ctrl_read(k, cgra_pkg::REG_STATUS);
         ctrl_read(k, cgra_pkg::REG_OPCODE);
         ctrl_read(k, cgra_pkg::REG_LENGTH);
         ctrl_read(k, cgra_pkg::REG_SRC_B);
         ctrl_read(k, cgra_pkg::REG_RUN);
         ctrl_read(k, 8'd7);
      end
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         ctrl_write(k, cgra_pkg::REG_OPCODE, cgra_pkg::data_t'(k + 5));
         ctrl_write(k, cgra_pkg::REG_SRC_B, 16'h0001);
         ctrl_write(k, cgra_pkg::REG_LENGTH, 16'd0);
         ctrl_read(k, cgra_pkg::REG_LENGTH);
         ctrl_write(k, cgra_pkg::REG_LENGTH, 16'd20);
         ctrl_read(k, cgra_pkg::REG_LENGTH);
         ctrl_read(k, cgra_pkg::REG_OPCODE);
         ctrl_read(k, cgra_pkg::REG_SRC_B);
      end

      // Operand banks of every core
      fill_operands();
      read_bank(cgra_pkg::BANK_A);
      read_bank(cgra_pkg::BANK_B);

      // One run from bank B with distinct opcodes and random lengths
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         config_core(k, (k * 3 + 1) % 8, int'(rand_word() % 16) + 1, 0);
      end
      run_and_check(0, 1'b0);
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         data_write(k, cgra_pkg::BANK_R, k + 1, rand_word());
         data_read(k, cgra_pkg::BANK_R, k + 1);
      end

      // Ring operands with lengths 16, 13, 10, 7
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         config_core(k, k + 4, 16 - 3 * k, 1);
      end
      run_and_check(1, 1'b0);

      // Run write while busy and A writes during the run
      for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
         config_core(k, (k * 3 + 2) % 8, int'(rand_word() % 8) + 9, 0);
      end
      run_and_check(2, 1'b1);
      read_bank(cgra_pkg::BANK_A);

      // Every opcode on every core with fresh operands
      for (int r = 0; r < 8; r++) begin
         fill_operands();
         for (int k = 0; k < cgra_pkg::N_CORE; k++) begin
            config_core(k, (r + k) % 8, int'(rand_word() % 16) + 1, 0);
         end
         run_and_check(r % cgra_pkg::N_CORE, 1'b0);
      end

      idle(3);
      $display("Checks: %0d, errors: %0d", n_checks, err_cnt);
      if (err_cnt == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/cgra_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_top (
   input  logic                 clk,
   input  logic                 rst,

   // Control bus
   input  logic                 ctr_req,
   input  logic                 ctr_rnw,
   input  cgra_pkg::host_addr_t ctr_addr,
   input  cgra_pkg::data_t      ctr_data_to_wr,
   output cgra_pkg::data_t      ctr_data_to_rd,

   // Data bus
   input  logic                 databus_req,
   input  logic                 databus_rnw,
   input  cgra_pkg::host_addr_t databus_addr,
   input  cgra_pkg::data_t      databus_data_in,
   output cgra_pkg::data_t      databus_data_out
);

   cgra_bus_if ctr_bus  [cgra_pkg::N_CORE] ();
   cgra_bus_if data_bus [cgra_pkg::N_CORE] ();

   cgra_pkg::data_t             ctr_rdata  [cgra_pkg::N_CORE];
   cgra_pkg::data_t             data_rdata [cgra_pkg::N_CORE];
   cgra_pkg::data_t             ring_data  [cgra_pkg::N_CORE];
   logic [cgra_pkg::N_CORE-1:0] ring_valid;
   logic [cgra_pkg::N_CORE-1:0] ctr_req_vec;
   logic [cgra_pkg::N_CORE-1:0] data_req_vec;
   cgra_pkg::core_sel_t         ctr_sel;
   cgra_pkg::core_sel_t         data_sel;
   cgra_pkg::core_sel_t         ctr_rd_sel;
   cgra_pkg::core_sel_t         data_rd_sel;
   logic                        ctr_rd_vld;
   logic                        data_rd_vld;
   logic                        run_req;

   // Upper address bits pick the core
   assign ctr_sel  = cgra_pkg::core_sel_t'(ctr_addr >> cgra_pkg::LOCAL_W);
   assign data_sel = cgra_pkg::core_sel_t'(databus_addr >> cgra_pkg::LOCAL_W);

   // Run write is broadcast whatever the core field holds
   assign run_req = ctr_req && !ctr_rnw &&
                    (cgra_pkg::local_addr_t'(ctr_addr) == cgra_pkg::REG_RUN);

   // Remember which core answers each read
   always_ff @(posedge clk) begin
      if (rst) begin
         ctr_rd_vld  <= 1'b0;
         ctr_rd_sel  <= '0;
         data_rd_vld <= 1'b0;
         data_rd_sel <= '0;
      end else begin
         if (ctr_req && ctr_rnw) begin
            ctr_rd_vld <= 1'b1;
            ctr_rd_sel <= ctr_sel;
         end
         if (databus_req && databus_rnw) begin
            data_rd_vld <= 1'b1;
            data_rd_sel <= data_sel;
         end
      end
   end

   assign ctr_data_to_rd   = ctr_rd_vld  ? ctr_rdata[ctr_rd_sel]   : '0;
   assign databus_data_out = data_rd_vld ? data_rdata[data_rd_sel] : '0;

   for (genvar g = 0; g < cgra_pkg::N_CORE; g++) begin : g_core
      // predecessor index, core 0 wraps to the last core
      localparam int PREV = (g + cgra_pkg::N_CORE - 1) % cgra_pkg::N_CORE;

      assign ctr_req_vec[g]    = ctr_req && (ctr_sel == cgra_pkg::core_sel_t'(g));
      assign ctr_bus[g].req    = ctr_req_vec[g];
      assign ctr_bus[g].rnw    = ctr_rnw;
      assign ctr_bus[g].addr   = cgra_pkg::local_addr_t'(ctr_addr);
      assign ctr_bus[g].wdata  = ctr_data_to_wr;
      assign ctr_rdata[g]      = ctr_bus[g].rdata;

      assign data_req_vec[g]   = databus_req && (data_sel == cgra_pkg::core_sel_t'(g));
      assign data_bus[g].req   = data_req_vec[g];
      assign data_bus[g].rnw   = databus_rnw;
      assign data_bus[g].addr  = cgra_pkg::local_addr_t'(databus_addr);
      assign data_bus[g].wdata = databus_data_in;
      assign data_rdata[g]     = data_bus[g].rdata;

      cgra_core core_i (
         .clk             (clk),
         .rst             (rst),
         .ctr             (ctr_bus[g]),
         .dbus            (data_bus[g]),
         .run_req         (run_req),
         .ring_prev_data  (ring_data[PREV]),
         .ring_prev_valid (ring_valid[PREV]),
         .ring_data       (ring_data[g]),
         .ring_valid      (ring_valid[g])
      );
   end

   // One core at most is addressed on each bus
   a_one_req: assert property (@(posedge clk) disable iff (rst)
      $onehot0(ctr_req_vec) && $onehot0(data_req_vec));

endmodule

`default_nettype wire

// ==== verilog/cgra_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_core (
   input  logic            clk,
   input  logic            rst,
   cgra_bus_if.core        ctr,
   cgra_bus_if.core        dbus,
   input  logic            run_req,
   input  cgra_pkg::data_t ring_prev_data,
   input  logic            ring_prev_valid,
   output cgra_pkg::data_t ring_data,
   output logic            ring_valid
);

   cgra_fu_pkg::eng_state_e state;
   cgra_fu_pkg::alu_op_e    opcode;
   cgra_fu_pkg::src_b_e     src_b;
   cgra_pkg::len_t          length;
   cgra_pkg::word_idx_t     step;
   cgra_pkg::word_idx_t     s1_idx;
   cgra_pkg::word_idx_t     s2_idx;
   cgra_pkg::data_t         a_data;
   cgra_pkg::data_t         b_data;
   cgra_pkg::data_t         b_sel;
   cgra_pkg::data_t         alu_result;
   logic                    busy;
   logic                    run_start;
   logic                    eng_done;
   logic                    rd_en;
   logic                    last_step;
   logic                    s1_valid;
   logic                    s1_last;
   logic                    s2_last;
   logic                    alu_valid;

   assign rd_en     = (state == cgra_fu_pkg::S_RUN);
   assign last_step = (cgra_pkg::len_t'(step) + cgra_pkg::len_t'(1) == length);

   // Step counter issues one index per cycle
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= cgra_fu_pkg::S_IDLE;
         step  <= '0;
      end else begin
         case (state)
            cgra_fu_pkg::S_IDLE: begin
               if (run_start) begin
                  state <= cgra_fu_pkg::S_RUN;
                  step  <= '0;
               end
            end
            cgra_fu_pkg::S_RUN: begin
               if (last_step) begin
                  state <= cgra_fu_pkg::S_DRAIN;
               end else begin
                  step <= step + 1'b1;
               end
            end
            cgra_fu_pkg::S_DRAIN: begin
               // wait for the last index to leave the ALU
               if (eng_done) begin
                  state <= cgra_fu_pkg::S_IDLE;
               end
            end
            default: state <= cgra_fu_pkg::S_IDLE;
         endcase
      end
   end

   // Index and last flag follow the bank read and ALU stages
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
         s1_last  <= 1'b0;
         s2_last  <= 1'b0;
      end else begin
         s1_valid <= rd_en;
         s1_last  <= rd_en && last_step;
         s2_last  <= s1_valid && s1_last;
      end
   end

   always_ff @(posedge clk) begin
      s1_idx <= step;
      s2_idx <= s1_idx;
   end

   assign eng_done   = alu_valid && s2_last;
   assign ring_data  = a_data;
   assign ring_valid = s1_valid;

   // Ring operand is zero past the predecessor's length
   always_comb begin
      if (src_b == cgra_fu_pkg::SRC_RING) begin
         b_sel = ring_prev_valid ? ring_prev_data : '0;
      end else begin
         b_sel = b_data;
      end
   end

   cgra_conf_regs conf_regs_i (
      .clk       (clk),
      .rst       (rst),
      .bus       (ctr),
      .run_req   (run_req),
      .eng_done  (eng_done),
      .opcode    (opcode),
      .length    (length),
      .src_b     (src_b),
      .busy      (busy),
      .run_start (run_start)
   );

   cgra_data_mem data_mem_i (
      .clk         (clk),
      .bus         (dbus),
      .eng_rd_en   (rd_en),
      .eng_rd_idx  (step),
      .a_data      (a_data),
      .b_data      (b_data),
      .eng_wr_en   (alu_valid),
      .eng_wr_idx  (s2_idx),
      .eng_wr_data (alu_result)
   );

   cgra_alu alu_i (
      .clk       (clk),
      .rst       (rst),
      .op        (opcode),
      .a         (a_data),
      .b         (b_sel),
      .in_valid  (s1_valid),
      .result    (alu_result),
      .out_valid (alu_valid)
   );

   // Result writes stay inside the programmed run and the busy window
   a_wr_in_range: assert property (@(posedge clk) disable iff (rst)
      alu_valid |-> busy && (cgra_pkg::len_t'(s2_idx) < length));

endmodule

`default_nettype wire

// ==== verilog/cgra_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_alu (
   input  logic                 clk,
   input  logic                 rst,
   input  cgra_fu_pkg::alu_op_e op,
   input  cgra_pkg::data_t      a,
   input  cgra_pkg::data_t      b,
   input  logic                 in_valid,
   output cgra_pkg::data_t      result,
   output logic                 out_valid
);

   cgra_pkg::data_t res_next;

   // All arithmetic wraps at 16 bits
   always_comb begin
      case (op)
         cgra_fu_pkg::OP_ADD:  res_next = a + b;
         cgra_fu_pkg::OP_SUB:  res_next = a - b;
         cgra_fu_pkg::OP_AND:  res_next = a & b;
         cgra_fu_pkg::OP_OR:   res_next = a | b;
         cgra_fu_pkg::OP_XOR:  res_next = a ^ b;
         cgra_fu_pkg::OP_MUL:  res_next = a * b;
         cgra_fu_pkg::OP_MAX:  res_next = (a > b) ? a : b;
         cgra_fu_pkg::OP_PASS: res_next = a;
         default:              res_next = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid <= 1'b0;
      end else begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         result <= res_next;
      end
   end

   // Opcode must be known whenever a step enters the ALU
   a_op_known: assert property (@(posedge clk) disable iff (rst)
      in_valid |-> !$isunknown(op));

endmodule

`default_nettype wire

// ==== verilog/cgra_data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_data_mem (
   input  logic                clk,
   cgra_bus_if.core            bus,
   input  logic                eng_rd_en,
   input  cgra_pkg::word_idx_t eng_rd_idx,
   output cgra_pkg::data_t     a_data,
   output cgra_pkg::data_t     b_data,
   input  logic                eng_wr_en,
   input  cgra_pkg::word_idx_t eng_wr_idx,
   input  cgra_pkg::data_t     eng_wr_data
);

   cgra_pkg::data_t     bank_a [cgra_pkg::BANK_WORDS];
   cgra_pkg::data_t     bank_b [cgra_pkg::BANK_WORDS];
   cgra_pkg::data_t     bank_r [cgra_pkg::BANK_WORDS];

   logic [1:0]          host_bank;
   cgra_pkg::word_idx_t host_idx;
   logic                host_wr;
   logic                host_rd;

   assign host_bank = bus.addr[cgra_pkg::BANK_LSB +: 2];
   assign host_idx  = cgra_pkg::word_idx_t'(bus.addr);
   assign host_wr   = bus.req && !bus.rnw;
   assign host_rd   = bus.req && bus.rnw;

   // Host owns A and B, bank R writes from the host are dropped
   always_ff @(posedge clk) begin
      if (host_wr && host_bank == cgra_pkg::BANK_A) begin
         bank_a[host_idx] <= bus.wdata;
      end
      if (host_wr && host_bank == cgra_pkg::BANK_B) begin
         bank_b[host_idx] <= bus.wdata;
      end
   end

   // Engine owns R
   always_ff @(posedge clk) begin
      if (eng_wr_en) begin
         bank_r[eng_wr_idx] <= eng_wr_data;
      end
   end

   // Engine operand fetch, both banks at the same index
   always_ff @(posedge clk) begin
      if (eng_rd_en) begin
         a_data <= bank_a[eng_rd_idx];
         b_data <= bank_b[eng_rd_idx];
      end
   end

   // Host read port, word held until the next read
   always_ff @(posedge clk) begin
      if (host_rd) begin
         case (host_bank)
            cgra_pkg::BANK_A: bus.rdata <= bank_a[host_idx];
            cgra_pkg::BANK_B: bus.rdata <= bank_b[host_idx];
            cgra_pkg::BANK_R: bus.rdata <= bank_r[host_idx];
            default:          bus.rdata <= '0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cgra_conf_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module cgra_conf_regs (
   input  logic                 clk,
   input  logic                 rst,
   cgra_bus_if.core             bus,
   input  logic                 run_req,
   input  logic                 eng_done,
   output cgra_fu_pkg::alu_op_e opcode,
   output cgra_pkg::len_t       length,
   output cgra_fu_pkg::src_b_e  src_b,
   output logic                 busy,
   output logic                 run_start
);

   logic           done;
   logic           wr_en;
   logic           rd_en;
   cgra_pkg::len_t len_clamped;

   assign wr_en = bus.req && !bus.rnw;
   assign rd_en = bus.req && bus.rnw;

   // Run only accepted while idle
   assign run_start = run_req && !busy;

   // Length limited to 1..BANK_WORDS
   always_comb begin
      if (bus.wdata == '0) begin
         len_clamped = cgra_pkg::len_t'(1);
      end else if (bus.wdata > cgra_pkg::data_t'(cgra_pkg::BANK_WORDS)) begin
         len_clamped = cgra_pkg::len_t'(cgra_pkg::BANK_WORDS);
      end else begin
         len_clamped = cgra_pkg::len_t'(bus.wdata);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         opcode <= cgra_fu_pkg::OP_ADD;
         length <= cgra_pkg::len_t'(1);
         src_b  <= cgra_fu_pkg::SRC_MEM;
      end else if (wr_en) begin
         case (bus.addr)
            cgra_pkg::REG_OPCODE: opcode <= cgra_fu_pkg::alu_op_e'(bus.wdata[2:0]);
            cgra_pkg::REG_LENGTH: length <= len_clamped;
            cgra_pkg::REG_SRC_B:  src_b  <= cgra_fu_pkg::src_b_e'(bus.wdata[0]);
            default: ;
         endcase
      end
   end

   // Busy from acceptance until the last result is written
   always_ff @(posedge clk) begin
      if (rst) begin
         busy <= 1'b0;
         done <= 1'b0;
      end else if (run_start) begin
         busy <= 1'b1;
         done <= 1'b0;
      end else if (eng_done) begin
         busy <= 1'b0;
         done <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bus.rdata <= '0;
      end else if (rd_en) begin
         case (bus.addr)
            cgra_pkg::REG_STATUS: bus.rdata <= cgra_pkg::data_t'({done, busy});
            cgra_pkg::REG_OPCODE: bus.rdata <= cgra_pkg::data_t'(opcode);
            cgra_pkg::REG_LENGTH: bus.rdata <= cgra_pkg::data_t'(length);
            cgra_pkg::REG_SRC_B:  bus.rdata <= cgra_pkg::data_t'(src_b);
            default:              bus.rdata <= '0;
         endcase
      end
   end

   // Engine completion only arrives inside an accepted run
   a_done_in_run: assert property (@(posedge clk) disable iff (rst)
      eng_done |-> busy);

endmodule

`default_nettype wire

// ==== verilog/cgra_bus_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// One host bus as seen by a single core
interface cgra_bus_if;

   logic                  req;
   logic                  rnw;
   cgra_pkg::local_addr_t addr;
   cgra_pkg::data_t       wdata;
   // Registered in the core, valid the cycle after req
   cgra_pkg::data_t       rdata;

   modport host (
      output req,
      output rnw,
      output addr,
      output wdata,
      input  rdata
   );

   modport core (
      input  req,
      input  rnw,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

// ==== verilog/cgra_fu_pkg.sv ====
`default_nettype none

package cgra_fu_pkg;

   // ALU operations, 3-bit opcode register
   typedef enum logic [2:0] {
      OP_ADD  = 3'd0,
      OP_SUB  = 3'd1,
      OP_AND  = 3'd2,
      OP_OR   = 3'd3,
      OP_XOR  = 3'd4,
      OP_MUL  = 3'd5,
      OP_MAX  = 3'd6,
      OP_PASS = 3'd7
   } alu_op_e;

   // Where operand b comes from
   typedef enum logic {
      SRC_MEM  = 1'b0,
      SRC_RING = 1'b1
   } src_b_e;

   // Engine FSM
   typedef enum logic [1:0] {
      S_IDLE  = 2'd0,
      S_RUN   = 2'd1,
      S_DRAIN = 2'd2
   } eng_state_e;

endpackage

`default_nettype wire

// ==== verilog/cgra_pkg.sv ====
`default_nettype none

package cgra_pkg;

   // Array size and field widths
   localparam int N_CORE     = 4;
   localparam int CORE_W     = $clog2(N_CORE);
   localparam int LOCAL_W    = 8;
   localparam int DATA_W     = 16;
   localparam int BANK_WORDS = 16;
   localparam int IDX_W      = $clog2(BANK_WORDS);
   localparam int LEN_W      = IDX_W + 1;

   typedef logic [DATA_W-1:0]         data_t;
   typedef logic [CORE_W-1:0]         core_sel_t;
   typedef logic [LOCAL_W-1:0]        local_addr_t;
   typedef logic [CORE_W+LOCAL_W-1:0] host_addr_t;
   typedef logic [IDX_W-1:0]          word_idx_t;
   typedef logic [LEN_W-1:0]          len_t;

   // Bank code in local address bits 5:4
   localparam int         BANK_LSB = 4;
   localparam logic [1:0] BANK_A   = 2'd0;
   localparam logic [1:0] BANK_B   = 2'd1;
   localparam logic [1:0] BANK_R   = 2'd2;

   // Per-core register map
   localparam local_addr_t REG_RUN    = 8'd0;
   localparam local_addr_t REG_STATUS = 8'd1;
   localparam local_addr_t REG_OPCODE = 8'd2;
   localparam local_addr_t REG_LENGTH = 8'd3;
   localparam local_addr_t REG_SRC_B  = 8'd4;

endpackage

`default_nettype wire
